/* Makefile */
# Verilator build and run of the 2D DMA testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary -f tb.f --top-module tb_top -Mdir obj_dir -o tb_sim
	@out="$$(./obj_dir/tb_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

/* rtl/dma_copy_backend.sv */
// --------------------------------------------------------------------------
// Copy backend, moves a row one word at a time over the memory port
// Each word is read from the source and then written to the destination
// --------------------------------------------------------------------------

`include "dma_defs.svh"

module dma_copy_backend
  import dma_xfer_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  burst_req_t burst_i,
  input  logic       burst_valid_i,
  output logic       burst_ready_o,
  output mem_req_t   mem_req_o,
  input  logic       mem_gnt_i,
  input  logic       mem_rvalid_i,
  input  data_t      mem_rdata_i,
  output logic       xfer_done_o,
  output logic       idle_o
);

  copy_state_e state_q;

  addr_t src_q;
  addr_t dst_q;
  len_t  len_q;
  logic  last_q;
  len_t  word_q;
  data_t data_q;
  addr_t offset;
  logic  last_word;
  logic  accept;
  logic  done_q;

  assign burst_ready_o = (state_q == CP_IDLE);
  assign idle_o        = (state_q == CP_IDLE);
  assign accept        = burst_valid_i && burst_ready_o;

  // Byte offset of the current word
  assign offset    = addr_t'({word_q, 2'b00});
  assign last_word = (word_q == len_q - len_t'(1));

  always_comb begin
    mem_req_o.req   = (state_q == CP_READ) || (state_q == CP_WRITE);
    mem_req_o.we    = (state_q == CP_WRITE);
    mem_req_o.addr  = (state_q == CP_WRITE) ? dst_q + offset : src_q + offset;
    mem_req_o.wdata = data_q;
  end

  // --------------------------------------------------------------------------
  // Burst and word datapath
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (accept) begin
      src_q  <= burst_i.src;
      dst_q  <= burst_i.dst;
      len_q  <= burst_i.len;
      last_q <= burst_i.last;
      word_q <= '0;
    end else if (state_q == CP_WRITE && mem_gnt_i) begin
      word_q <= word_q + len_t'(1);
    end
    if (state_q == CP_WAIT_DATA && mem_rvalid_i) begin
      data_q <= mem_rdata_i;
    end
  end

  // --------------------------------------------------------------------------
  // Copy FSM
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= CP_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        CP_IDLE: begin
          if (accept) begin
            // Empty row finishes here, no memory access
            if (burst_i.len == '0) begin
              done_q <= burst_i.last;
            end else begin
              state_q <= CP_READ;
            end
          end
        end
        CP_READ: begin
          if (mem_gnt_i) state_q <= CP_WAIT_DATA;
        end
        CP_WAIT_DATA: begin
          if (mem_rvalid_i) state_q <= CP_WRITE;
        end
        CP_WRITE: begin
          if (mem_gnt_i) begin
            if (last_word) begin
              state_q <= CP_IDLE;
              done_q  <= last_q;
            end else begin
              state_q <= CP_READ;
            end
          end
        end
        default: state_q <= CP_IDLE;
      endcase
    end
  end

  assign xfer_done_o = done_q;

endmodule

/* rtl/dma_defs.svh */
// --------------------------------------------------------------------------
// Global widths and sizes of the 2D DMA controller
// Included by both packages and by every RTL module
// --------------------------------------------------------------------------

`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// Datapath widths
`define DMA_ADDR_W 32
`define DMA_DATA_W 32

// Descriptor field widths
`define DMA_LEN_W  16
`define DMA_REPS_W 16
`define DMA_ID_W   16

// Register port and descriptor queue
`define DMA_REG_ADDR_W 3
`define DMA_FIFO_DEPTH 4

`endif

/* rtl/dma_nd_midend.sv */
// --------------------------------------------------------------------------
// 2D midend, splits a descriptor into one burst per row
// Row addresses advance by the source and destination strides
// --------------------------------------------------------------------------

`include "dma_defs.svh"

module dma_nd_midend
  import dma_xfer_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  nd_req_t    desc_i,
  input  logic       desc_valid_i,
  output logic       desc_ready_o,
  output burst_req_t burst_o,
  output logic       burst_valid_o,
  input  logic       burst_ready_i,
  output logic       idle_o
);

  midend_state_e state_q;

  addr_t src_q;
  addr_t dst_q;
  addr_t src_stride_q;
  addr_t dst_stride_q;
  len_t  len_q;
  reps_t row_q;
  reps_t last_row_q;
  logic  last_row;

  assign desc_ready_o  = (state_q == MID_IDLE);
  assign burst_valid_o = (state_q == MID_EMIT);
  assign idle_o        = (state_q == MID_IDLE);
  assign last_row      = (row_q == last_row_q);

  always_comb begin
    burst_o.src  = src_q;
    burst_o.dst  = dst_q;
    burst_o.len  = len_q;
    burst_o.last = last_row;
  end

  // Row datapath
  always_ff @(posedge clk_i) begin
    if (desc_valid_i && desc_ready_o) begin
      src_q        <= desc_i.src;
      dst_q        <= desc_i.dst;
      src_stride_q <= desc_i.src_stride;
      dst_stride_q <= desc_i.dst_stride;
      row_q        <= '0;
      // No rows at all becomes a single empty row
      if (desc_i.reps == '0) begin
        len_q      <= '0;
        last_row_q <= '0;
      end else begin
        len_q      <= desc_i.len;
        last_row_q <= desc_i.reps - reps_t'(1);
      end
    end else if (burst_valid_o && burst_ready_i && !last_row) begin
      src_q <= src_q + src_stride_q;
      dst_q <= dst_q + dst_stride_q;
      row_q <= row_q + reps_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= MID_IDLE;
    end else begin
      case (state_q)
        MID_IDLE: if (desc_valid_i) state_q <= MID_EMIT;
        MID_EMIT: if (burst_ready_i && last_row) state_q <= MID_IDLE;
        default:  state_q <= MID_IDLE;
      endcase
    end
  end

endmodule

/* rtl/dma_reg_frontend.sv */
// --------------------------------------------------------------------------
// Register frontend of the DMA controller
// Collects a descriptor from the core port and launches it on a read of
// the next-id register; counts completions and raises the event pulse
// --------------------------------------------------------------------------

`include "dma_defs.svh"

module dma_reg_frontend
  import dma_reg_pkg::*;
  import dma_xfer_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  output nd_req_t  desc_o,
  output logic     desc_valid_o,
  input  logic     desc_ready_i,
  input  logic     xfer_done_i,
  output logic     term_event_o
);

  // Descriptor registers
  addr_t src_q;
  addr_t dst_q;
  len_t  len_q;
  addr_t src_stride_q;
  addr_t dst_stride_q;
  reps_t reps_q;

  xfer_id_t next_id_q;
  xfer_id_t done_q;
  xfer_id_t launch_id;

  logic  launch_req;
  logic  gnt;
  logic  rd_fire;
  logic  rvalid_q;
  data_t rdata_q;
  data_t rdata_d;
  logic  term_event_q;

  // Only a launch can be held off, and only by a full queue
  assign launch_req = reg_req_i.req && !reg_req_i.we && (reg_req_i.idx == REG_NEXT_ID);
  assign gnt        = reg_req_i.req && (!launch_req || desc_ready_i);
  assign rd_fire    = gnt && !reg_req_i.we;
  assign launch_id  = next_id_q + xfer_id_t'(1);

  always_comb begin
    desc_o.src        = src_q;
    desc_o.dst        = dst_q;
    desc_o.len        = len_q;
    desc_o.src_stride = src_stride_q;
    desc_o.dst_stride = dst_stride_q;
    desc_o.reps       = reps_q;
  end

  assign desc_valid_o = launch_req;

  // --------------------------------------------------------------------------
  // Register writes
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (reg_req_i.req && reg_req_i.we) begin
      case (reg_req_i.idx)
        REG_SRC:        src_q        <= reg_req_i.wdata;
        REG_DST:        dst_q        <= reg_req_i.wdata;
        REG_LEN:        len_q        <= len_t'(reg_req_i.wdata);
        REG_SRC_STRIDE: src_stride_q <= reg_req_i.wdata;
        REG_DST_STRIDE: dst_stride_q <= reg_req_i.wdata;
        REG_REPS:       reps_q       <= reps_t'(reg_req_i.wdata);
        default: ;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Read response
  // --------------------------------------------------------------------------

  always_comb begin
    rdata_d = '0;
    case (reg_req_i.idx)
      REG_SRC:        rdata_d = src_q;
      REG_DST:        rdata_d = dst_q;
      REG_LEN:        rdata_d = data_t'(len_q);
      REG_SRC_STRIDE: rdata_d = src_stride_q;
      REG_DST_STRIDE: rdata_d = dst_stride_q;
      REG_REPS:       rdata_d = data_t'(reps_q);
      REG_NEXT_ID:    rdata_d = data_t'(launch_id);
      REG_DONE_ID:    rdata_d = data_t'(done_q);
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      rdata_q <= rdata_d;
    end
  end

  // Counters and strobes
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      next_id_q    <= '0;
      done_q       <= '0;
      rvalid_q     <= 1'b0;
      term_event_q <= 1'b0;
    end else begin
      rvalid_q     <= rd_fire;
      term_event_q <= xfer_done_i;
      if (launch_req && desc_ready_i) begin
        next_id_q <= launch_id;
      end
      if (xfer_done_i) begin
        done_q <= done_q + xfer_id_t'(1);
      end
    end
  end

  always_comb begin
    reg_rsp_o.gnt    = gnt;
    reg_rsp_o.rvalid = rvalid_q;
    reg_rsp_o.rdata  = rdata_q;
  end

  assign term_event_o = term_event_q;

endmodule

/* rtl/dma_reg_pkg.sv */
// --------------------------------------------------------------------------
// Types of the core register port of the DMA controller
// --------------------------------------------------------------------------

`include "dma_defs.svh"

package dma_reg_pkg;

  typedef logic [`DMA_DATA_W-1:0] reg_data_t;

  // Register map, one word per register
  typedef enum logic [`DMA_REG_ADDR_W-1:0] {
    REG_SRC        = 3'd0,
    REG_DST        = 3'd1,
    REG_LEN        = 3'd2,
    REG_SRC_STRIDE = 3'd3,
    REG_DST_STRIDE = 3'd4,
    REG_REPS       = 3'd5,
    REG_NEXT_ID    = 3'd6,
    REG_DONE_ID    = 3'd7
  } reg_idx_e;

  typedef struct packed {
    logic      req;
    logic      we;
    reg_idx_e  idx;
    reg_data_t wdata;
  } reg_req_t;

  typedef struct packed {
    logic      gnt;
    logic      rvalid;
    reg_data_t rdata;
  } reg_rsp_t;

endpackage

/* rtl/dma_req_fifo.sv */
// --------------------------------------------------------------------------
// Descriptor queue between the register frontend and the midend
// Circular buffer with valid/ready on both sides, output from flops
// --------------------------------------------------------------------------

`include "dma_defs.svh"

module dma_req_fifo #(
  parameter int unsigned DEPTH = `DMA_FIFO_DEPTH,
  parameter type         T     = logic
) (
  input  logic clk_i,
  input  logic reset_i,
  input  T     data_i,
  input  logic valid_i,
  output logic ready_o,
  output T     data_o,
  output logic valid_o,
  input  logic ready_i,
  output logic empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  T mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign ready_o = (count_q != CNT_W'(DEPTH));
  assign valid_o = (count_q != '0);
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i && ready_o;
  assign pop  = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      if (push && !pop) begin
        count_q <= count_q + CNT_W'(1);
      end else if (pop && !push) begin
        count_q <= count_q - CNT_W'(1);
      end
    end
  end

endmodule

/* rtl/dma_top.sv */
// --------------------------------------------------------------------------
// Top level of the 2D DMA controller
// Register frontend, descriptor FIFO, 2D midend and copy backend in a row
// --------------------------------------------------------------------------

`include "dma_defs.svh"

module dma_top
  import dma_reg_pkg::*;
  import dma_xfer_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  output mem_req_t mem_req_o,
  input  logic     mem_gnt_i,
  input  logic     mem_rvalid_i,
  input  data_t    mem_rdata_i,
  output logic     term_event_o,
  output logic     busy_o
);

  nd_req_t    fe_desc;
  nd_req_t    fifo_desc;
  burst_req_t burst;

  logic fe_valid;
  logic fe_ready;
  logic fifo_valid;
  logic fifo_ready;
  logic fifo_empty;
  logic burst_valid;
  logic burst_ready;
  logic mid_idle;
  logic be_idle;
  logic xfer_done;
  logic busy_q;

  dma_reg_frontend i_frontend (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .reg_req_i    ( reg_req_i    ),
    .reg_rsp_o    ( reg_rsp_o    ),
    .desc_o       ( fe_desc      ),
    .desc_valid_o ( fe_valid     ),
    .desc_ready_i ( fe_ready     ),
    .xfer_done_i  ( xfer_done    ),
    .term_event_o ( term_event_o )
  );

  dma_req_fifo #(
    .DEPTH ( `DMA_FIFO_DEPTH ),
    .T     ( nd_req_t        )
  ) i_req_fifo (
    .clk_i   ( clk_i      ),
    .reset_i ( reset_i    ),
    .data_i  ( fe_desc    ),
    .valid_i ( fe_valid   ),
    .ready_o ( fe_ready   ),
    .data_o  ( fifo_desc  ),
    .valid_o ( fifo_valid ),
    .ready_i ( fifo_ready ),
    .empty_o ( fifo_empty )
  );

  dma_nd_midend i_midend (
    .clk_i         ( clk_i       ),
    .reset_i       ( reset_i     ),
    .desc_i        ( fifo_desc   ),
    .desc_valid_i  ( fifo_valid  ),
    .desc_ready_o  ( fifo_ready  ),
    .burst_o       ( burst       ),
    .burst_valid_o ( burst_valid ),
    .burst_ready_i ( burst_ready ),
    .idle_o        ( mid_idle    )
  );

  dma_copy_backend i_backend (
    .clk_i         ( clk_i        ),
    .reset_i       ( reset_i      ),
    .burst_i       ( burst        ),
    .burst_valid_i ( burst_valid  ),
    .burst_ready_o ( burst_ready  ),
    .mem_req_o     ( mem_req_o    ),
    .mem_gnt_i     ( mem_gnt_i    ),
    .mem_rvalid_i  ( mem_rvalid_i ),
    .mem_rdata_i   ( mem_rdata_i  ),
    .xfer_done_o   ( xfer_done    ),
    .idle_o        ( be_idle      )
  );

  // Busy while any stage still holds work
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= !fifo_empty || !mid_idle || !be_idle;
    end
  end

  assign busy_o = busy_q;

endmodule

/* rtl/dma_xfer_pkg.sv */
// --------------------------------------------------------------------------
// Transfer types shared by the DMA pipeline stages
// Descriptor, row burst and memory port, plus the stage FSM states
// --------------------------------------------------------------------------

`include "dma_defs.svh"

package dma_xfer_pkg;

  typedef logic [`DMA_ADDR_W-1:0] addr_t;
  typedef logic [`DMA_DATA_W-1:0] data_t;
  typedef logic [`DMA_LEN_W-1:0]  len_t;
  typedef logic [`DMA_REPS_W-1:0] reps_t;
  typedef logic [`DMA_ID_W-1:0]   xfer_id_t;

  // Full 2D transfer, strides in bytes
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  len;
    addr_t src_stride;
    addr_t dst_stride;
    reps_t reps;
  } nd_req_t;

  // One row of a transfer
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  len;
    logic  last;
  } burst_req_t;

  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
  } mem_req_t;

  typedef enum logic [0:0] {
    MID_IDLE,
    MID_EMIT
  } midend_state_e;

  typedef enum logic [1:0] {
    CP_IDLE,
    CP_READ,
    CP_WAIT_DATA,
    CP_WRITE
  } copy_state_e;

endpackage

/* tb.f */
+incdir+rtl
rtl/dma_reg_pkg.sv
rtl/dma_xfer_pkg.sv
rtl/dma_reg_frontend.sv
rtl/dma_req_fifo.sv
rtl/dma_nd_midend.sv
rtl/dma_copy_backend.sv
rtl/dma_top.sv
tb/tb_checker.sv
tb/tb_top.sv

/* tb/tb_checker.sv */
// --------------------------------------------------------------------------
// Watches the DMA ports, predicts every memory write and read response
// and reports each finished transfer
// --------------------------------------------------------------------------

module tb_checker
  import dma_reg_pkg::*;
  import dma_xfer_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  reg_req_t reg_req_i,
  input  reg_rsp_t reg_rsp_i,
  input  mem_req_t mem_req_i,
  input  logic     mem_gnt_i,
  input  logic     term_event_i,
  output int       err_count_o,
  output int       done_count_o
);

  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    addr_t addr;
    data_t data;
  } wr_t;

  nd_req_t  shadow;
  wr_t      exp_q[$];
  int       end_q[$];
  xfer_id_t id_q[$];
  xfer_id_t next_id;
  wr_t      exp_wr;
  xfer_id_t fin_id;
  int       fin_end;
  int       last_end;
  int       pushed;
  int       seen;
  int       errors;
  int       done_count;
  logic     rd_pending;
  data_t    rd_exp;

  assign err_count_o  = errors;
  assign done_count_o = done_count;

  // Write n of a descriptor, rows first then words within a row
  function automatic wr_t expected_write(input nd_req_t d, input int n);
    wr_t w;
    int  r;
    int  k;
    r = n / int'(d.len);
    k = n % int'(d.len);
    w.addr = d.dst + addr_t'(r) * d.dst_stride + addr_t'(4 * k);
    w.data = (d.src + addr_t'(r) * d.src_stride + addr_t'(4 * k)) ^ 32'hA5A5_0000;
    return w;
  endfunction

  always @(posedge clk_i) begin
    if (reset_i) begin
      next_id    = 1;
      rd_pending = 1'b0;
      pushed     = 0;
      seen       = 0;
      last_end   = 0;
      errors     = 0;
      done_count = 0;
    end else begin
      if (rd_pending && !reg_rsp_i.rvalid) begin
        errors++;
        $display("read at %0t got no response one cycle after its grant", $time);
      end else if (rd_pending && reg_rsp_i.rdata !== rd_exp) begin
        errors++;
        $display("ERROR t=%0t reg_rsp_o.rdata expected %h got %h",
                 $time, rd_exp, reg_rsp_i.rdata);
      end
      rd_pending = 1'b0;

      // Completions come before reads, the done count already includes them
      if (term_event_i) begin
        done_count++;
        if (end_q.size() == 0) begin
          errors++;
          $display("completion event at %0t with no transfer in flight", $time);
        end else begin
          fin_end = end_q.pop_front();
          fin_id  = id_q.pop_front();
          if (seen != fin_end) begin
            errors++;
            $display("transfer %0d completed at %0t with %0d writes missing",
                     fin_id, $time, fin_end - seen);
          end else begin
            $display("transfer %0d complete, %0d writes checked", fin_id, fin_end - last_end);
          end
          last_end = fin_end;
        end
      end

      if (mem_req_i.req && mem_req_i.we && mem_gnt_i) begin
        seen++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("unexpected memory write at %0t to %h", $time, mem_req_i.addr);
        end else begin
          exp_wr = exp_q.pop_front();
          if (mem_req_i.addr !== exp_wr.addr) begin
            errors++;
            $display("ERROR t=%0t mem_req_o.addr expected %h got %h",
                     $time, exp_wr.addr, mem_req_i.addr);
          end
          if (mem_req_i.wdata !== exp_wr.data) begin
            errors++;
            $display("ERROR t=%0t mem_req_o.wdata expected %h got %h",
                     $time, exp_wr.data, mem_req_i.wdata);
          end
        end
      end

      if (reg_req_i.req && reg_rsp_i.gnt && reg_req_i.we) begin
        case (reg_req_i.idx)
          REG_SRC:        shadow.src        = reg_req_i.wdata;
          REG_DST:        shadow.dst        = reg_req_i.wdata;
          REG_LEN:        shadow.len        = len_t'(reg_req_i.wdata);
          REG_SRC_STRIDE: shadow.src_stride = reg_req_i.wdata;
          REG_DST_STRIDE: shadow.dst_stride = reg_req_i.wdata;
          REG_REPS:       shadow.reps       = reps_t'(reg_req_i.wdata);
          default: ;
        endcase
      end else if (reg_req_i.req && reg_rsp_i.gnt && reg_req_i.idx == REG_NEXT_ID) begin
        for (int n = 0; n < int'(shadow.reps) * int'(shadow.len); n++) begin
          exp_q.push_back(expected_write(shadow, n));
          pushed++;
        end
        end_q.push_back(pushed);
        id_q.push_back(next_id);
        rd_exp     = data_t'(next_id);
        rd_pending = 1'b1;
        next_id    = next_id + xfer_id_t'(1);
      end else if (reg_req_i.req && reg_rsp_i.gnt && reg_req_i.idx == REG_DONE_ID) begin
        rd_exp     = data_t'(xfer_id_t'(done_count));
        rd_pending = 1'b1;
      end
    end
  end

endmodule

/* tb/tb_top.sv */
// --------------------------------------------------------------------------
// Testbench top of the 2D DMA controller
// Drives the core port, models the memory port and runs the test groups
// --------------------------------------------------------------------------

module tb_top
  import dma_reg_pkg::*;
  import dma_xfer_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 40;
  // Words moved by all tests together
  localparam int TOTAL_WORDS     = 8 + 12 + 6 * 8 + 0 + 4 * 10;
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 40 + 2000;

  logic     clk;
  logic     reset;
  reg_req_t reg_req;
  reg_rsp_t reg_rsp;
  mem_req_t mem_req;
  logic     mem_gnt;
  logic     mem_rvalid;
  data_t    mem_rdata;
  logic     term_event;
  logic     busy;

  logic [31:0] lfsr_q;
  logic        stall_heavy;
  logic        rd_hit;
  addr_t       rd_addr;
  int          launched;
  int          tb_errors;
  int          chk_errors;
  int          done_count;
  int          reported;

  dma_top dut_i (
    .clk_i        ( clk        ),
    .reset_i      ( reset      ),
    .reg_req_i    ( reg_req    ),
    .reg_rsp_o    ( reg_rsp    ),
    .mem_req_o    ( mem_req    ),
    .mem_gnt_i    ( mem_gnt    ),
    .mem_rvalid_i ( mem_rvalid ),
    .mem_rdata_i  ( mem_rdata  ),
    .term_event_o ( term_event ),
    .busy_o       ( busy       )
  );

  tb_checker chk_i (
    .clk_i        ( clk        ),
    .reset_i      ( reset      ),
    .reg_req_i    ( reg_req    ),
    .reg_rsp_i    ( reg_rsp    ),
    .mem_req_i    ( mem_req    ),
    .mem_gnt_i    ( mem_gnt    ),
    .term_event_i ( term_event ),
    .err_count_o  ( chk_errors ),
    .done_count_o ( done_count )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Memory model with random grant stalls
  // --------------------------------------------------------------------------

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic data_t mem_pattern(input addr_t a);
    return a ^ 32'hA5A5_0000;
  endfunction

  task automatic draw_grant(output logic g);
    lfsr_q = lfsr_step(lfsr_q);
    g = lfsr_q[0];
    // Heavy stalls need a second one bit
    if (stall_heavy) begin
      lfsr_q = lfsr_step(lfsr_q);
      g = g & lfsr_q[0];
    end
  endtask

  initial begin
    mem_gnt    = 1'b0;
    mem_rvalid = 1'b0;
    mem_rdata  = '0;
    lfsr_q     = 32'h6185;
    forever begin
      @(posedge clk);
      rd_hit  = mem_req.req && !mem_req.we && mem_gnt;
      rd_addr = mem_req.addr;
      #2;
      mem_rvalid = rd_hit;
      mem_rdata  = rd_hit ? mem_pattern(rd_addr) : '0;
      if (mem_req.req) begin
        draw_grant(mem_gnt);
      end else begin
        mem_gnt = 1'b0;
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired at %0t with %0d of %0d transfers complete",
             $time, done_count, launched);
    $display("RESULT: FAIL");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Core port tasks
  // --------------------------------------------------------------------------

  task automatic reg_access(input logic we, input reg_idx_e idx, input data_t wdata);
    reg_req.req   = 1'b1;
    reg_req.we    = we;
    reg_req.idx   = idx;
    reg_req.wdata = wdata;
    do begin
      @(posedge clk);
    end while (!reg_rsp.gnt);
    #2;
    reg_req.req = 1'b0;
    // Read data arrives one cycle after the grant
    if (!we) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic launch(input addr_t src, input addr_t dst, input len_t len,
                        input addr_t src_stride, input addr_t dst_stride, input reps_t reps);
    reg_access(1'b1, REG_SRC, src);
    reg_access(1'b1, REG_DST, dst);
    reg_access(1'b1, REG_LEN, data_t'(len));
    reg_access(1'b1, REG_SRC_STRIDE, src_stride);
    reg_access(1'b1, REG_DST_STRIDE, dst_stride);
    reg_access(1'b1, REG_REPS, data_t'(reps));
    reg_access(1'b0, REG_NEXT_ID, '0);
    launched++;
  endtask

  task automatic wait_done();
    do begin
      @(posedge clk);
      #2;
    end while (done_count != launched || busy);
  endtask

  task automatic check_idle();
    if (busy !== 1'b0) begin
      tb_errors++;
      $display("ERROR t=%0t busy_o expected 0 got %b", $time, busy);
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    wait_done();
    errs = tb_errors + chk_errors;
    if (errs == reported) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: FAILED with %0d errors", name, errs - reported);
    end
    reported = errs;
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial begin
    reg_req     = '0;
    reset       = 1'b1;
    stall_heavy = 1'b0;
    launched    = 0;
    tb_errors   = 0;
    reported    = 0;
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    @(posedge clk);
    #2;
    check_idle();

    launch(32'h0000_1000, 32'h0000_8000, 16'd8, 32'd0, 32'd0, 16'd1);
    end_test("1 single row copy");

    launch(32'h0000_2000, 32'h0000_9000, 16'd3, 32'd64, 32'd32, 16'd4);
    end_test("2 strided 2D copy");

    // More launches than the queue holds
    for (int i = 0; i < 6; i++) begin
      launch(32'h0000_3000 + addr_t'(i * 256), 32'h0000_A000 + addr_t'(i * 256),
             16'd4, 32'd32, 32'd32, 16'd2);
    end
    wait_done();
    reg_access(1'b0, REG_DONE_ID, '0);
    end_test("3 back to back launches");

    launch(32'h0000_5000, 32'h0000_B000, 16'd5, 32'd64, 32'd64, 16'd0);
    launch(32'h0000_5000, 32'h0000_B000, 16'd0, 32'd64, 32'd64, 16'd3);
    end_test("4 empty transfers");

    stall_heavy = 1'b1;
    for (int i = 0; i < 4; i++) begin
      launch(32'h0000_4000 + addr_t'(i * 512), 32'h0000_C000 + addr_t'(i * 512),
             16'd5, 32'd64, 32'd64, 16'd2);
    end
    end_test("5 heavy memory stalls");
    repeat (4) begin
      @(posedge clk);
      #2;
      check_idle();
    end

    $display("summary: %0d launched, %0d completed, %0d errors",
             launched, done_count, tb_errors + chk_errors);
    if (tb_errors + chk_errors == 0 && done_count == launched) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
